// File: hw/burst_page_splitter.sv
// splits one source command into sink pieces of at most BS_SINK_MAX_BURST beats
// no piece crosses a BS_PAGE_BEATS boundary, the page size is a power of two
// piece size and last flag are registered, so piece_cmd comes from flops only
`timescale 1ns/1ps
`include "burst_split_cfg.svh"

module burst_page_splitter (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       cmd_valid,
    input  burst_split_pkg::src_cmd_t  cmd,
    output logic                       cmd_ready,

    output logic                       piece_valid,
    output burst_split_pkg::sink_cmd_t piece_cmd,
    input  logic                       piece_ready
);

    // bits of the address that give the offset inside a page
    localparam int PAGE_BITS = $clog2(`BS_PAGE_BEATS);

    // wide enough for a source count and for a full page of beats
    localparam int SPAN_W = (`BS_SRC_BURST_WIDTH > PAGE_BITS + 1) ?
                            `BS_SRC_BURST_WIDTH : PAGE_BITS + 1;

    typedef logic [SPAN_W-1:0] span_t;

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t state;

    // current piece, its size and last flag are held ready for the sink
    burst_split_pkg::addr_t      cur_addr;
    burst_split_pkg::src_count_t remain;
    burst_split_pkg::sink_count_t piece_size;
    logic                        piece_last;

    logic take;
    logic accept;

    // values for the piece that follows the current edge
    burst_split_pkg::addr_t       adv_addr;
    burst_split_pkg::src_count_t  adv_remain;
    burst_split_pkg::addr_t       load_addr;
    burst_split_pkg::src_count_t  load_remain;
    burst_split_pkg::sink_count_t load_size;
    logic                         load_last;

    // size of the piece that starts at addr with rem beats still to go
    // it is the smallest of the remaining count, the sink maximum and the page tail
    function automatic burst_split_pkg::sink_count_t piece_span(
        burst_split_pkg::addr_t      addr,
        burst_split_pkg::src_count_t rem
    );
        span_t page_left;
        span_t size;

        page_left = span_t'(`BS_PAGE_BEATS) - span_t'(addr[PAGE_BITS-1:0]);
        size      = span_t'(rem);
        if (size > span_t'(`BS_SINK_MAX_BURST))
        begin
            size = span_t'(`BS_SINK_MAX_BURST);
        end
        if (size > page_left)
        begin
            size = page_left;
        end
        return burst_split_pkg::sink_count_t'(size);
    endfunction

    assign piece_valid = (state == BUSY);
    assign accept      = piece_valid && piece_ready;

    // a new command enters when idle or as the last piece leaves
    assign cmd_ready = (state == IDLE) || (accept && piece_last);
    assign take      = cmd_valid && cmd_ready;

    assign piece_cmd.addr  = cur_addr;
    assign piece_cmd.count = piece_size;
    assign piece_cmd.last  = piece_last;

    always_comb
    begin
        // where the command stands once the current piece is gone
        adv_addr   = cur_addr + burst_split_pkg::addr_t'(piece_size);
        adv_remain = remain - burst_split_pkg::src_count_t'(piece_size);

        // a new command takes priority over the finished one
        if (take)
        begin
            load_addr   = cmd.addr;
            load_remain = cmd.count;
        end
        else
        begin
            load_addr   = adv_addr;
            load_remain = adv_remain;
        end

        load_size = piece_span(load_addr, load_remain);
        // the piece is the last one when it swallows everything left
        load_last = (burst_split_pkg::src_count_t'(load_size) == load_remain);
    end

    // command registers carry payload and are only meaningful while busy
    always_ff @(posedge clk)
    begin
        if (take || (accept && !piece_last))
        begin
            cur_addr   <= load_addr;
            remain     <= load_remain;
            piece_size <= load_size;
            piece_last <= load_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (take)
                    begin
                        state <= BUSY;
                    end
                end
                BUSY:
                begin
                    // stay busy when the next command arrives right behind
                    if (accept && piece_last && !take)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/burst_split_cfg.svh
// build-time configuration for the burst splitter
// burst counts are origin 1 (1 is one beat, 0 is illegal) and addresses count beats
// BS_PAGE_BEATS must be a power of two and larger than BS_SINK_MAX_BURST
`ifndef BURST_SPLIT_CFG_SVH
`define BURST_SPLIT_CFG_SVH

// beat address width
`define BS_ADDR_WIDTH 16

// count field widths, one extra bit holds the full power-of-two maximum
`define BS_SRC_BURST_WIDTH 7
`define BS_SINK_BURST_WIDTH 4

// largest legal counts, derived from the field widths
`define BS_SRC_MAX_BURST (1 << (`BS_SRC_BURST_WIDTH - 1))
`define BS_SINK_MAX_BURST (1 << (`BS_SINK_BURST_WIDTH - 1))

// no sink burst may cross a boundary of this many beats
`define BS_PAGE_BEATS 32

// entries in the source command queue
`define BS_QUEUE_DEPTH 4

`endif

// File: hw/burst_split_pkg.sv
// command types shared by the burst splitter stages
// count fields use the origin 1 encoding, so the maximum burst needs the top bit
`include "burst_split_cfg.svh"

package burst_split_pkg;

    // beat address
    typedef logic [`BS_ADDR_WIDTH-1:0] addr_t;

    // source side burst count, 1 up to BS_SRC_MAX_BURST
    typedef logic [`BS_SRC_BURST_WIDTH-1:0] src_count_t;

    // sink side burst count, 1 up to BS_SINK_MAX_BURST
    typedef logic [`BS_SINK_BURST_WIDTH-1:0] sink_count_t;

    // one command as issued by the source
    typedef struct packed {
        addr_t      addr;
        src_count_t count;
    } src_cmd_t;

    // one piece as presented to the sink
    // last is set only on the final piece of a source command
    typedef struct packed {
        addr_t       addr;
        sink_count_t count;
        logic        last;
    } sink_cmd_t;

endpackage

// File: hw/burst_split_top.sv
// burst splitter subsystem: command queue, page-aware splitter, sink skid buffer
// commands only, no data beats and no responses pass through here
// first sink_valid comes 3 cycles after a source transfer into an empty subsystem
`timescale 1ns/1ps
`include "burst_split_cfg.svh"

module burst_split_top (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       src_valid,
    input  burst_split_pkg::src_cmd_t  src_cmd,
    output logic                       src_ready,

    output logic                       sink_valid,
    output burst_split_pkg::sink_cmd_t sink_cmd,
    input  logic                       sink_ready
);

    // queue to splitter
    logic                       q_valid;
    burst_split_pkg::src_cmd_t  q_cmd;
    logic                       q_ready;

    // splitter to skid buffer
    logic                       piece_valid;
    burst_split_pkg::sink_cmd_t piece_cmd;
    logic                       piece_ready;

    src_cmd_queue #(
        .DEPTH(`BS_QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (src_valid),
        .in_cmd    (src_cmd),
        .in_ready  (src_ready),
        .out_valid (q_valid),
        .out_cmd   (q_cmd),
        .out_ready (q_ready)
    );

    burst_page_splitter u_splitter (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd_valid   (q_valid),
        .cmd         (q_cmd),
        .cmd_ready   (q_ready),
        .piece_valid (piece_valid),
        .piece_cmd   (piece_cmd),
        .piece_ready (piece_ready)
    );

    sink_cmd_skid u_skid (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (piece_valid),
        .in_cmd    (piece_cmd),
        .in_ready  (piece_ready),
        .out_valid (sink_valid),
        .out_cmd   (sink_cmd),
        .out_ready (sink_ready)
    );

endmodule

// File: hw/sink_cmd_skid.sv
// two entry skid buffer in front of the sink
// in_ready is registered and stays high while the spare entry is empty
`timescale 1ns/1ps

module sink_cmd_skid (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       in_valid,
    input  burst_split_pkg::sink_cmd_t in_cmd,
    output logic                       in_ready,

    output logic                       out_valid,
    output burst_split_pkg::sink_cmd_t out_cmd,
    input  logic                       out_ready
);

    // main register drives the sink, spare catches the stall cycle
    logic                       main_valid;
    burst_split_pkg::sink_cmd_t main_cmd;
    logic                       spare_valid;
    burst_split_pkg::sink_cmd_t spare_cmd;

    logic in_fire;
    logic out_fire;

    assign in_ready  = !spare_valid;
    assign out_valid = main_valid;
    assign out_cmd   = main_cmd;

    assign in_fire  = in_valid && in_ready;
    assign out_fire = main_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end
        else if (spare_valid)
        begin
            // input is closed, the spare moves up once the sink takes main
            if (out_fire)
            begin
                main_cmd    <= spare_cmd;
                spare_valid <= 1'b0;
            end
        end
        else if (in_fire)
        begin
            if (!main_valid || out_fire)
            begin
                // main is free or draining, the new piece goes straight out
                main_cmd   <= in_cmd;
                main_valid <= 1'b1;
            end
            else
            begin
                // sink stalled while a piece was accepted
                spare_cmd   <= in_cmd;
                spare_valid <= 1'b1;
            end
        end
        else if (out_fire)
        begin
            main_valid <= 1'b0;
        end
    end

endmodule

// File: hw/src_cmd_queue.sv
// circular FIFO of source commands with valid/ready on both ends
// DEPTH must be two or more and need not be a power of two
// in_ready and out_valid come straight from the occupancy count
`timescale 1ns/1ps

module src_cmd_queue #(
    parameter int DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      reset_n,

    input  logic                      in_valid,
    input  burst_split_pkg::src_cmd_t in_cmd,
    output logic                      in_ready,

    output logic                      out_valid,
    output burst_split_pkg::src_cmd_t out_cmd,
    input  logic                      out_ready
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    burst_split_pkg::src_cmd_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    logic push;
    logic pop;

    // ready is low exactly when every entry holds a word
    assign in_ready  = (count != cnt_t'(DEPTH));
    assign out_valid = (count != cnt_t'(0));
    assign out_cmd   = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // storage has no reset, only the words below count are ever read
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in_cmd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // pointers wrap explicitly so any depth works
            if (push)
            begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            // a read and write in the same cycle leave the count alone
            case ({push, pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src.f
+incdir+hw
hw/burst_split_pkg.sv
hw/src_cmd_queue.sv
hw/burst_page_splitter.sv
hw/sink_cmd_skid.sv
hw/burst_split_top.sv
verif/tb_clock.sv
verif/burst_split_tb.sv

// File: verif/burst_split_tb.sv
// testbench for burst_split_top with a directed table and then 200 random commands
// expected sink pieces come from a model of the page and sink maximum rules
// sink_ready modes are 0 always high, 1 stalled for a while, 2 random
`timescale 1ns/1ps
`include "burst_split_cfg.svh"

module burst_split_tb;

    localparam int NUM_VECTORS  = 16;
    localparam int NUM_RANDOM   = 200;
    localparam int STALL_CYCLES = 60;
    localparam int LIMIT_CYCLES = (NUM_VECTORS + NUM_RANDOM) * 40 + 200;

    // one directed source command with its expected piece count
    typedef struct packed {
        logic [15:0] addr;
        logic [6:0]  count;
        logic [3:0]  pieces;
        logic [1:0]  mode;
    } vec_t;

    logic                       clk;
    logic                       reset_n;
    logic                       src_valid;
    burst_split_pkg::src_cmd_t  src_cmd;
    logic                       src_ready;
    logic                       sink_valid;
    burst_split_pkg::sink_cmd_t sink_cmd;
    logic                       sink_ready;

    // expected pieces in order, and the beat total of each source command
    burst_split_pkg::sink_cmd_t exp_pieces [$];
    int                         exp_totals [$];

    logic [31:0] stim_state;
    logic [31:0] ready_state;
    logic [1:0]  ready_mode;
    int          stall_cnt;
    int          beat_sum;
    logic        seen_full;

    // stall entries carry mode 1 and the last one blocks until the sink wakes up
    vec_t vectors [NUM_VECTORS] = '{
        '{16'h0004, 7'd8,  4'd1, 2'd0},
        '{16'h0100, 7'd1,  4'd1, 2'd0},
        '{16'h0040, 7'd64, 4'd8, 2'd0},
        '{16'h001d, 7'd10, 4'd2, 2'd0},
        '{16'h0033, 7'd20, 4'd3, 2'd0},
        '{16'hfffe, 7'd4,  4'd2, 2'd0},
        '{16'h0010, 7'd64, 4'd8, 2'd2},
        '{16'h0200, 7'd8,  4'd1, 2'd1},
        '{16'h0208, 7'd8,  4'd1, 2'd1},
        '{16'h021c, 7'd6,  4'd2, 2'd1},
        '{16'h0300, 7'd16, 4'd2, 2'd1},
        '{16'h0400, 7'd3,  4'd1, 2'd1},
        '{16'h041f, 7'd2,  4'd2, 2'd1},
        '{16'h0500, 7'd8,  4'd1, 2'd1},
        '{16'h0508, 7'd8,  4'd1, 2'd1},
        '{16'h0600, 7'd7,  4'd1, 2'd0}
    };

    tb_clock u_clock (
        .clk     (clk),
        .reset_n (reset_n)
    );

    burst_split_top u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .src_valid  (src_valid),
        .src_cmd    (src_cmd),
        .src_ready  (src_ready),
        .sink_valid (sink_valid),
        .sink_cmd   (sink_cmd),
        .sink_ready (sink_ready)
    );

    // 32 bit Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // takes n fresh bits from the stimulus LFSR with one step per bit
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            stim_state = lfsr_step(stim_state);
            value      = {value[30:0], stim_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // cuts a source command into pieces limited by the remaining count,
    // the sink maximum and the beats left in the current page
    function automatic int predict_pieces(input int addr, input int count);
        burst_split_pkg::sink_cmd_t p;
        int a;
        int rem;
        int size;
        int n;

        a   = addr;
        rem = count;
        n   = 0;
        while (rem > 0)
        begin
            size = `BS_PAGE_BEATS - (a % `BS_PAGE_BEATS);
            if (size > `BS_SINK_MAX_BURST)
                size = `BS_SINK_MAX_BURST;
            if (size > rem)
                size = rem;
            p.addr  = a[15:0];
            p.count = size[3:0];
            p.last  = (size == rem);
            exp_pieces.push_back(p);
            a   = (a + size) % 65536;
            rem = rem - size;
            n++;
        end
        exp_totals.push_back(count);
        return n;
    endfunction

    // holds one source command on the port until the queue accepts it
    task automatic send_cmd(input int addr, input int count);
        src_valid     <= 1'b1;
        src_cmd.addr  <= addr[15:0];
        src_cmd.count <= count[6:0];
        @(posedge clk);
        while (!src_ready)
            @(posedge clk);
    endtask

    // sink back-pressure where a stall lasts STALL_CYCLES and then lets go
    always @(posedge clk)
    begin
        if (ready_mode == 2'd1)
        begin
            sink_ready <= (stall_cnt >= STALL_CYCLES);
            stall_cnt  <= stall_cnt + 1;
        end
        else if (ready_mode == 2'd2)
        begin
            ready_state = lfsr_step(ready_state);
            sink_ready  <= ready_state[0];
            stall_cnt   <= 0;
        end
        else
        begin
            sink_ready <= 1'b1;
            stall_cnt  <= 0;
        end
    end

    // the sink monitor matches every transfer against the model in order
    always @(posedge clk)
    begin
        if (reset_n && !src_ready)
            seen_full = 1'b1;
        if (reset_n && sink_valid && sink_ready)
        begin
            if (exp_pieces.size() == 0)
            begin
                $display("a sink command arrived that the reference model did not predict");
                $display("TEST FAIL");
                $fatal(1, "extra sink transfer");
            end
            check_value("sink_cmd.addr", sink_cmd.addr, exp_pieces[0].addr);
            check_value("sink_cmd.count", sink_cmd.count, exp_pieces[0].count);
            check_value("sink_cmd.last", sink_cmd.last, exp_pieces[0].last);
            void'(exp_pieces.pop_front());
            // a piece may never reach past the end of its page
            check_value("sink_cmd page overrun",
                        (sink_cmd.addr % `BS_PAGE_BEATS) + sink_cmd.count > `BS_PAGE_BEATS,
                        0);
            beat_sum = beat_sum + sink_cmd.count;
            if (sink_cmd.last)
            begin
                check_value("source beat total", beat_sum, exp_totals.pop_front());
                beat_sum = 0;
            end
        end
    end

    // watchdog sized from the number of source commands
    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("the run timed out after %0d cycles without finishing", LIMIT_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [31:0] r_addr;
        logic [31:0] r_count;
        int          n;

        src_valid   = 1'b0;
        src_cmd     = '0;
        sink_ready  = 1'b0;
        ready_mode  = 2'd0;
        stall_cnt   = 0;
        beat_sum    = 0;
        seen_full   = 1'b0;
        stim_state  = 32'h875e;
        ready_state = 32'h875e;

        @(posedge clk);
        while (!reset_n)
            @(posedge clk);
        check_value("sink_valid", sink_valid, 1'b0);
        check_value("src_ready", src_ready, 1'b1);

        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            ready_mode <= vectors[i].mode;
            n = predict_pieces(vectors[i].addr, vectors[i].count);
            check_value("expected piece count", n, vectors[i].pieces);
            send_cmd(vectors[i].addr, vectors[i].count);
        end
        // the stall run must have filled the queue at some point
        check_value("src_ready seen low", seen_full, 1'b1);

        ready_mode <= 2'd2;
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            draw_bits(16, r_addr);
            draw_bits(6, r_count);
            void'(predict_pieces(r_addr, r_count + 1));
            send_cmd(r_addr, r_count + 1);
        end
        src_valid  <= 1'b0;
        ready_mode <= 2'd0;

        while (exp_pieces.size() != 0)
            @(posedge clk);
        // nothing may follow once every predicted piece has arrived
        repeat (8) @(posedge clk);
        check_value("sink_valid", sink_valid, 1'b0);

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: verif/tb_clock.sv
// clock and reset source for the burst splitter testbench
// 20 ns period, reset_n is held low for the first 4 rising edges
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset_n
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // release is synchronous, it follows the fourth rising edge
    initial
    begin
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule
